/* Makefile */
TOP = dec_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f decode_unit.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "no result in log"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* decode_unit.f */
+incdir+hw
hw/dec_pkg.sv
hw/dec_ib_ctl.sv
hw/dec_decode_ctl.sv
hw/dec_gpr_ctl.sv
hw/dec.sv
sim/dec_assert.sv
sim/dec_tb.sv

/* hw/dec.sv */
`include "dec_params.svh"

module dec import dec_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_valid,
  input  fetch_pkt_t fetch,
  output logic       ib_ready,
  output logic       d_valid,
  output dec_pkt_t   d_pkt,
  input  logic       exu_ready,
  input  reg_wr_t    wb,        // execution write-back
  input  reg_wr_t    ld_rsp     // load return
);

  logic                   head_valid;  // buffer -> decoder
  fetch_pkt_t             head;
  logic                   head_pop;
  logic [`DEC_REG_AW-1:0] rs1_addr;    // decoder -> gpr
  logic [`DEC_REG_AW-1:0] rs2_addr;
  logic [`DEC_XLEN-1:0]   rs1_data;    // gpr -> decoder
  logic [`DEC_XLEN-1:0]   rs2_data;

  dec_ib_ctl instbuff (
    .clk(clk), .rst_n(rst_n),
    .fetch_valid(fetch_valid), .fetch(fetch), .ib_ready(ib_ready),
    .head_valid(head_valid), .head(head), .head_pop(head_pop)
  );

  dec_decode_ctl decode (
    .clk(clk), .rst_n(rst_n),
    .head_valid(head_valid), .head(head), .head_pop(head_pop),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .ld_rsp(ld_rsp),
    .d_valid(d_valid), .d_pkt(d_pkt), .exu_ready(exu_ready)
  );

  dec_gpr_ctl arf (
    .clk(clk), .rst_n(rst_n),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wb(wb), .ld_rsp(ld_rsp)
  );

endmodule

/* hw/dec_decode_ctl.sv */
`include "dec_params.svh"

module dec_decode_ctl import dec_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   head_valid,  // buffer head present
  input  fetch_pkt_t             head,
  output logic                   head_pop,    // head decoded this edge
  output logic [`DEC_REG_AW-1:0] rs1_addr,    // to gpr read port 0
  output logic [`DEC_REG_AW-1:0] rs2_addr,    // to gpr read port 1
  input  logic [`DEC_XLEN-1:0]   rs1_data,
  input  logic [`DEC_XLEN-1:0]   rs2_data,
  input  reg_wr_t                ld_rsp,      // load return clears busy
  output logic                   d_valid,
  output dec_pkt_t               d_pkt,
  input  logic                   exu_ready
);

  logic [`DEC_XLEN-1:0]     instr;
  logic [`DEC_REG_AW-1:0]   rd;
  dec_op_e                  op;
  logic [`DEC_XLEN-1:0]     imm;
  logic                     use_rs1;    // class reads rs1
  logic                     use_rs2;    // class reads rs2
  logic                     use_rd;     // class writes rd
  logic [`DEC_NUM_REGS-1:0] busy;       // pending load destinations
  logic [`DEC_NUM_REGS-1:0] busy_set;
  logic [`DEC_NUM_REGS-1:0] busy_clr;
  logic                     hazard;
  logic                     out_free;   // output reg empty or being taken
  logic                     decode_go;

  assign instr    = head.instr;
  assign rd       = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // **************************************************
  // class, register usage and immediate
  // **************************************************
  always_comb begin
    op      = OP_ILLEGAL;  // unknown major opcode
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    case (instr[6:0])
      7'b0110011: begin  // op
        op      = OP_ALU;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
      end
      7'b0010011: begin  // op-imm, i-type
        op      = OP_ALUI;
        imm     = {{20{instr[31]}}, instr[31:20]};
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      7'b0110111: begin  // lui, u-type
        op     = OP_LUI;
        imm    = {instr[31:12], 12'b0};
        use_rd = 1'b1;
      end
      7'b0000011: begin  // load, i-type
        op      = OP_LOAD;
        imm     = {{20{instr[31]}}, instr[31:20]};
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      7'b0100011: begin  // store, s-type
        op      = OP_STORE;
        imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      7'b1100011: begin  // branch, b-type
        op      = OP_BRANCH;
        imm     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      7'b1101111: begin  // jal, j-type
        op     = OP_JAL;
        imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        use_rd = 1'b1;
      end
      default: ;
    endcase
  end

  // **************************************************
  // load scoreboard and stall
  // **************************************************
  // busy is the registered view only, a same-edge return still stalls
  assign hazard = (use_rs1 & busy[rs1_addr]) |
                  (use_rs2 & busy[rs2_addr]) |
                  (use_rd  & busy[rd]);

  assign out_free  = ~d_valid | exu_ready;
  assign decode_go = head_valid & out_free & ~hazard;
  assign head_pop  = decode_go;

  assign busy_set = (decode_go && op == OP_LOAD && rd != '0) ?
                    (`DEC_NUM_REGS'(1) << rd) : '0;             // x0 never busy
  assign busy_clr = ld_rsp.en ? (`DEC_NUM_REGS'(1) << ld_rsp.addr) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= '0;
      d_valid <= 1'b0;
    end else begin
      busy    <= (busy & ~busy_clr) | busy_set;
      d_valid <= decode_go | (d_valid & ~exu_ready);  // hold until taken
    end
  end

  // decode output register
  always_ff @(posedge clk) begin
    if (decode_go) begin
      d_pkt.op       <= op;
      d_pkt.rd       <= rd;
      d_pkt.rs1      <= rs1_addr;
      d_pkt.rs2      <= rs2_addr;
      d_pkt.rs1_data <= rs1_data;  // write-through from gpr
      d_pkt.rs2_data <= rs2_data;
      d_pkt.imm      <= imm;
      d_pkt.instr    <= instr;
      d_pkt.pc       <= head.pc;
    end
  end

endmodule

/* hw/dec_gpr_ctl.sv */
`include "dec_params.svh"

module dec_gpr_ctl import dec_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DEC_REG_AW-1:0] rs1_addr,
  input  logic [`DEC_REG_AW-1:0] rs2_addr,
  output logic [`DEC_XLEN-1:0]   rs1_data,
  output logic [`DEC_XLEN-1:0]   rs2_data,
  input  reg_wr_t                wb,      // execution write-back
  input  reg_wr_t                ld_rsp   // load return, higher priority
);

  logic [`DEC_XLEN-1:0] regs [1:`DEC_NUM_REGS-1];  // x0 not stored

  // read with same-edge write forwarding
  function automatic logic [`DEC_XLEN-1:0] rd_port(input logic [`DEC_REG_AW-1:0] ra);
    logic [`DEC_XLEN-1:0] val;
    if (ra == '0) begin
      val = '0;                                  // x0 reads zero
    end else if (ld_rsp.en && ld_rsp.addr == ra) begin
      val = ld_rsp.data;
    end else if (wb.en && wb.addr == ra) begin
      val = wb.data;
    end else begin
      val = regs[ra];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data = rd_port(rs1_addr);
    rs2_data = rd_port(rs2_addr);
  end

  // **************************************************
  // write ports, ld_rsp wins on a collision
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `DEC_NUM_REGS; i++) regs[i] <= '0;
    end else begin
      for (int i = 1; i < `DEC_NUM_REGS; i++) begin
        if (ld_rsp.en && ld_rsp.addr == `DEC_REG_AW'(i)) begin
          regs[i] <= ld_rsp.data;
        end else if (wb.en && wb.addr == `DEC_REG_AW'(i)) begin
          regs[i] <= wb.data;
        end
      end
    end
  end

endmodule

/* hw/dec_ib_ctl.sv */
`include "dec_params.svh"

module dec_ib_ctl import dec_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_valid,  // fetch side offers an instruction
  input  fetch_pkt_t fetch,
  output logic       ib_ready,     // at least one entry free
  output logic       head_valid,   // oldest entry present
  output fetch_pkt_t head,
  input  logic       head_pop      // decoder consumes the head
);

  localparam int PW = $clog2(`DEC_IB_DEPTH);      // pointer width
  localparam int CW = $clog2(`DEC_IB_DEPTH + 1);  // count width

  fetch_pkt_t        q [`DEC_IB_DEPTH];  // entry storage
  logic [PW-1:0]     rd_ptr;
  logic [PW-1:0]     wr_ptr;
  logic [CW-1:0]     count;
  logic              push;
  logic              pop;

  assign ib_ready   = (count != CW'(`DEC_IB_DEPTH));
  assign head_valid = (count != '0);
  assign head       = q[rd_ptr];  // oldest first

  assign push = fetch_valid & ib_ready;
  assign pop  = head_pop & head_valid;

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(`DEC_IB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(`DEC_IB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end                                  // push and pop together, count holds
    end
  end

  // entry write, payload only
  always_ff @(posedge clk) begin
    if (push) begin
      q[wr_ptr] <= fetch;
    end
  end

endmodule

/* hw/dec_params.svh */
`ifndef DEC_PARAMS_SVH
`define DEC_PARAMS_SVH

// **************************************************
// decode stage sizing
// **************************************************

`define DEC_XLEN      32  // register and data width
`define DEC_NUM_REGS  32  // x0..x31
`define DEC_REG_AW    5   // register address width
`define DEC_IB_DEPTH  4   // instruction buffer entries

`endif

/* hw/dec_pkg.sv */
`include "dec_params.svh"

package dec_pkg;

  // **************************************************
  // opcode classes, picked by the major opcode
  // **************************************************
  typedef enum logic [2:0] {
    OP_ALU     = 3'd0,  // reg-reg alu
    OP_ALUI    = 3'd1,  // reg-imm alu
    OP_LUI     = 3'd2,  // upper immediate
    OP_LOAD    = 3'd3,  // non-blocking load
    OP_STORE   = 3'd4,
    OP_BRANCH  = 3'd5,  // conditional branch
    OP_JAL     = 3'd6,
    OP_ILLEGAL = 3'd7   // anything else
  } dec_op_e;

  // fetch packet into the instruction buffer
  typedef struct packed {
    logic [`DEC_XLEN-1:0] instr;  // 32b instruction word
    logic [`DEC_XLEN-1:1] pc;     // halfword pc
  } fetch_pkt_t;

  // decode packet handed to execution
  typedef struct packed {
    dec_op_e               op;        // opcode class
    logic [`DEC_REG_AW-1:0] rd;
    logic [`DEC_REG_AW-1:0] rs1;
    logic [`DEC_REG_AW-1:0] rs2;
    logic [`DEC_XLEN-1:0]   rs1_data;  // gpr read, rs1
    logic [`DEC_XLEN-1:0]   rs2_data;  // gpr read, rs2
    logic [`DEC_XLEN-1:0]   imm;       // sign extended
    logic [`DEC_XLEN-1:0]   instr;     // original word
    logic [`DEC_XLEN-1:1]   pc;
  } dec_pkt_t;

  // register write port, used for wb and load return
  typedef struct packed {
    logic                   en;
    logic [`DEC_REG_AW-1:0] addr;
    logic [`DEC_XLEN-1:0]   data;
  } reg_wr_t;

endpackage

/* sim/dec_assert.sv */
`include "dec_params.svh"

module dec_assert import dec_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       head_valid,
  input fetch_pkt_t head,
  input logic       head_pop,
  input logic       d_valid,
  input dec_pkt_t   d_pkt,
  input logic       exu_ready,
  input reg_wr_t    ld_rsp,
  input logic       use_rs1,
  input logic       use_rs2,
  input logic       use_rd,
  input logic [4:0] rs1_addr,
  input logic [4:0] rs2_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`DEC_NUM_REGS-1:0] pend;     // loads popped, data not back yet
  logic [4:0]               head_rd;
  logic                     blocked;  // a used register waits on a load
  logic                     may_go;   // head free to decode this edge

  assign head_rd = head.instr[11:7];
  assign blocked = (use_rs1 && pend[rs1_addr]) || (use_rs2 && pend[rs2_addr]) ||
                   (use_rd && pend[head_rd]);
  assign may_go  = head_valid && (!d_valid || exu_ready) && !blocked;

  // shadow scoreboard from popped load words and load returns
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      if (ld_rsp.en) begin
        pend[ld_rsp.addr] <= 1'b0;
      end
      if (head_pop && head.instr[6:0] == 7'b0000011 && head_rd != 5'd0) begin
        pend[head_rd] <= 1'b1;  // new load wins over a return
      end
    end
  end

  // held packet must not move until taken
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (d_valid && !exu_ready) |=> (d_valid && $stable(d_pkt)))
    else $error("decode packet changed while stalled");

  // pop only with a head present, and never hold a head that may go
  a_pop: assert property (@(posedge clk) disable iff (!rst_n)
    head_pop == may_go)
    else $error("pop does not match head, slot and scoreboard state");

  // no decode over a pending load source
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    head_pop |-> !((use_rs1 && pend[rs1_addr]) || (use_rs2 && pend[rs2_addr])))
    else $error("decoded with busy source");

endmodule

bind dec_decode_ctl dec_assert u_dec_assert (
  .clk(clk), .rst_n(rst_n), .head_valid(head_valid), .head(head), .head_pop(head_pop),
  .d_valid(d_valid), .d_pkt(d_pkt), .exu_ready(exu_ready), .ld_rsp(ld_rsp),
  .use_rs1(use_rs1), .use_rs2(use_rs2), .use_rd(use_rd),
  .rs1_addr(rs1_addr), .rs2_addr(rs2_addr)
);

/* sim/dec_tb.sv */
`include "dec_params.svh"

module dec_tb import dec_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic          fv;     // fetch offered this entry
    logic [31:0]   instr;
    logic [31:1]   pc;
    reg_wr_t       wb;
    reg_wr_t       ld;
    logic [1:0]    exu;    // 0 low, 1 high, 2 random
    dec_op_e       op;     // expected class
    logic [31:0]   imm;    // expected immediate
    logic          full;   // expect ib_ready low
    logic [3:0]    maxp;   // max outstanding, f = no check
  } stim_t;

  logic       clk;
  logic       rst_n;
  logic       fetch_valid;
  fetch_pkt_t fetch;
  logic       ib_ready;
  logic       d_valid;
  dec_pkt_t   d_pkt;
  logic       exu_ready;
  reg_wr_t    wb;
  reg_wr_t    ld_rsp;

  stim_t        table_q[$];
  stim_t        exp_q[$];     // fetched, not yet taken
  stim_t        cur;          // entry on the fetch bus now
  logic [31:0]  ref_regs [32];
  logic [31:0]  busy_ref;
  logic [31:0]  lcg_state;
  logic [31:1]  pc_next;
  int           wd_limit;

  dec DUT (
    .clk(clk), .rst_n(rst_n), .fetch_valid(fetch_valid), .fetch(fetch),
    .ib_ready(ib_ready), .d_valid(d_valid), .d_pkt(d_pkt), .exu_ready(exu_ready),
    .wb(wb), .ld_rsp(ld_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // **************************************************
  // encoders and small helpers
  // **************************************************
  function automatic logic [31:0] enc_r(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [6:0] opc, logic [4:0] rd, logic [4:0] rs1,
                                        logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic reg_wr_t wr(logic en, logic [4:0] addr, logic [31:0] data);
    return '{en: en, addr: addr, data: data};
  endfunction

  // {rs1, rs2, rd} used by each class
  function automatic logic [2:0] uses(dec_op_e op);
    case (op)
      OP_ALU:              return 3'b111;
      OP_ALUI, OP_LOAD:    return 3'b101;
      OP_STORE, OP_BRANCH: return 3'b110;
      OP_LUI, OP_JAL:      return 3'b001;
      default:             return 3'b000;
    endcase
  endfunction

  function automatic logic lcg_bit();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[16];
  endfunction

  function automatic logic exu_val(logic [1:0] mode);
    if (mode == 2'd2) return lcg_bit();
    return mode[0];
  endfunction

  task automatic add(logic fv, logic [31:0] instr, dec_op_e op, logic [31:0] imm,
                     logic [1:0] exu, reg_wr_t w, reg_wr_t l, logic full, logic [3:0] maxp);
    stim_t e;
    e = '{fv: fv, instr: instr, pc: pc_next, wb: w, ld: l, exu: exu, op: op, imm: imm,
          full: full, maxp: maxp};
    table_q.push_back(e);
    if (fv) pc_next = pc_next + 31'd2;  // 4 bytes per word
  endtask

  task automatic idle(logic [1:0] exu, reg_wr_t w, reg_wr_t l);
    add(1'b0, '0, OP_ILLEGAL, '0, exu, w, l, 1'b0, 4'hf);
  endtask

  // **************************************************
  // failure reporting and compare tasks
  // **************************************************
  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_op(string name, dec_op_e exp, dec_op_e act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      fail_now("opcode class mismatch");
    end
  endtask

  task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      fail_now("data word mismatch");
    end
  endtask

  task automatic check_reg(string name, logic [4:0] exp, logic [4:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      fail_now("register field mismatch");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      fail_now("control signal mismatch");
    end
  endtask

  // **************************************************
  // monitor and reference model
  // **************************************************
  always @(posedge clk) begin : monitor
    stim_t      e;
    logic [2:0] u;
    if (rst_n) begin
      if (d_valid && exu_ready) begin           // packet taken this edge
        if (exp_q.size() == 0) fail_now("decode packet with nothing outstanding");
        e = exp_q.pop_front();
        u = uses(e.op);
        check_op("d_pkt.op", e.op, d_pkt.op);
        check_reg("d_pkt.rd", e.instr[11:7], d_pkt.rd);
        check_reg("d_pkt.rs1", e.instr[19:15], d_pkt.rs1);
        check_reg("d_pkt.rs2", e.instr[24:20], d_pkt.rs2);
        check_word("d_pkt.rs1_data", ref_regs[e.instr[19:15]], d_pkt.rs1_data);
        check_word("d_pkt.rs2_data", ref_regs[e.instr[24:20]], d_pkt.rs2_data);
        check_word("d_pkt.imm", e.imm, d_pkt.imm);
        check_word("d_pkt.instr", e.instr, d_pkt.instr);
        check_word("d_pkt.pc", {1'b0, e.pc}, {1'b0, d_pkt.pc});
        if ((u[2] && busy_ref[e.instr[19:15]]) || (u[1] && busy_ref[e.instr[24:20]]) ||
            (u[0] && busy_ref[e.instr[11:7]]))
          fail_now("instruction issued while its load was still pending");
        if (e.op == OP_LOAD && e.instr[11:7] != 5'd0) busy_ref[e.instr[11:7]] = 1'b1;
      end
      if (wb.en && wb.addr != 5'd0) ref_regs[wb.addr] = wb.data;
      if (ld_rsp.en && ld_rsp.addr != 5'd0) ref_regs[ld_rsp.addr] = ld_rsp.data;  // wins
      if (ld_rsp.en) busy_ref[ld_rsp.addr] = 1'b0;
      if (fetch_valid && ib_ready) exp_q.push_back(cur);
    end
  end

  // **************************************************
  // stimulus
  // **************************************************
  initial begin : stimulus
    stim_t e;
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch       = '0;
    exu_ready   = 1'b0;
    wb          = '0;
    ld_rsp      = '0;
    cur         = '0;
    busy_ref    = '0;
    lcg_state   = 32'hadd3;
    pc_next     = 31'h400;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;

    // register setup, x0 write ignored
    idle(1, wr(1, 1, 32'h100), '0);
    idle(1, wr(1, 2, 32'h22), '0);
    idle(1, wr(1, 3, 32'hfffffff0), '0);
    idle(1, wr(1, 0, 32'hdead), '0);
    add(1, enc_r(4, 1, 2), OP_ALU, '0, 1, '0, '0, 0, 4'hf);
    add(1, enc_i(7'b0010011, 5, 3, 12'hffb), OP_ALUI, 32'hfffffffb, 1, '0, '0, 0, 4'hf);
    add(1, enc_s(1, 3, 12'hff4), OP_STORE, 32'hfffffff4, 1, '0, '0, 0, 4'hf);
    add(1, enc_b(2, 1, 13'h1ff0), OP_BRANCH, 32'hfffffff0, 1, '0, '0, 0, 4'hf);
    add(1, {20'habcde, 5'd9, 7'b0110111}, OP_LUI, 32'habcde000, 1, '0, '0, 0, 4'hf);
    add(1, enc_j(10, 21'h000800), OP_JAL, 32'h800, 1, '0, '0, 0, 4'hf);
    add(1, enc_r(8, 0, 0), OP_ALU, '0, 1, '0, '0, 0, 4'hf);
    repeat (3) idle(1, '0, '0);
    // x7 written on the decode edge of the read
    add(1, enc_r(6, 1, 7), OP_ALU, '0, 1, '0, '0, 0, 4'hf);
    idle(1, wr(1, 7, 32'h77), '0);
    repeat (2) idle(1, '0, '0);
    // load, independent op, dependent op
    add(1, enc_i(7'b0000011, 11, 1, 12'h004), OP_LOAD, 32'h4, 1, '0, '0, 0, 4'hf);
    add(1, enc_i(7'b0010011, 12, 2, 12'h003), OP_ALUI, 32'h3, 1, '0, '0, 0, 4'hf);
    add(1, enc_r(13, 11, 2), OP_ALU, '0, 1, '0, '0, 0, 4'hf);
    repeat (3) idle(1, '0, '0);
    add(0, '0, OP_ILLEGAL, '0, 1, '0, wr(1, 11, 32'h1234abcd), 0, 4'd1);
    repeat (3) idle(1, '0, '0);
    // back-pressure, 1 held + 4 buffered
    for (int k = 1; k <= 5; k++)
      add(1, enc_i(7'b0010011, 14, 1, 12'(k)), OP_ALUI, 32'(k), 0, '0, '0, 0, 4'hf);
    add(0, '0, OP_ILLEGAL, '0, 0, '0, '0, 1, 4'hf);
    idle(0, '0, '0);
    idle(1, '0, '0);
    // random exu_ready mix, illegal opcode included
    add(1, 32'hdeadbeff, OP_ILLEGAL, '0, 2, '0, '0, 0, 4'hf);
    add(1, enc_r(15, 3, 11), OP_ALU, '0, 2, '0, '0, 0, 4'hf);
    add(1, enc_s(2, 7, 12'h7ff), OP_STORE, 32'h7ff, 2, '0, '0, 0, 4'hf);
    add(1, enc_b(3, 4, 13'h0ffe), OP_BRANCH, 32'hffe, 2, '0, '0, 0, 4'hf);
    add(1, enc_j(16, 21'h1ffffe), OP_JAL, 32'hfffffffe, 2, '0, '0, 0, 4'hf);
    add(1, enc_i(7'b0010011, 17, 11, 12'h800), OP_ALUI, 32'hfffff800, 2, '0, '0, 0, 4'hf);
    add(1, 32'h0000007f, OP_ILLEGAL, '0, 2, '0, '0, 0, 4'hf);
    add(1, {20'h00001, 5'd18, 7'b0110111}, OP_LUI, 32'h1000, 2, '0, '0, 0, 4'hf);
    repeat (2) idle(2, '0, '0);
    repeat (4) idle(1, '0, '0);
    wd_limit = 50 * table_q.size() + 100;

    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    check_bit("d_valid", 1'b0, d_valid);
    check_bit("ib_ready", 1'b1, ib_ready);

    foreach (table_q[i]) begin
      e = table_q[i];
      @(posedge clk);
      #1;
      cur         = e;
      fetch_valid = e.fv;
      fetch       = '{instr: e.instr, pc: e.pc};
      wb          = e.wb;
      ld_rsp      = e.ld;
      exu_ready   = exu_val(e.exu);
      if (e.full) check_bit("ib_ready", 1'b0, ib_ready);
      if (e.maxp != 4'hf && exp_q.size() > int'(e.maxp))
        fail_now("independent instruction was held behind a pending load");
      while (e.fv && !ib_ready) begin           // buffer full, retry
        @(posedge clk);
        #1;
        wb        = '0;
        ld_rsp    = '0;
        exu_ready = exu_val(e.exu);
      end
    end
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
    wb          = '0;
    ld_rsp      = '0;
    exu_ready   = 1'b1;
    while (exp_q.size() != 0) @(posedge clk);  // drain
    $display("TEST RESULT: PASS");
    $finish;
  end

  // watchdog sized from the table
  initial begin : watchdog
    wait (wd_limit > 0);
    repeat (wd_limit) @(posedge clk);
    $display("the run timed out before all instructions came out");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

endmodule
